//--- project.f
logic/cpuPkg.sv
logic/wordMemory.sv
logic/alu.sv
logic/registerFile.sv
logic/decodeUnit.sv
logic/fetchUnit.sv
logic/processor.sv
dv/clockGen.sv
dv/processor_properties.sv
dv/processorTb.sv

//--- Bender.yml
package:
  name: processor

sources:
  - logic/cpuPkg.sv
  - logic/wordMemory.sv
  - logic/alu.sv
  - logic/registerFile.sv
  - logic/decodeUnit.sv
  - logic/fetchUnit.sv
  - logic/processor.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/processor_properties.sv
      - dv/processorTb.sv

//--- dv/processorTb.sv
// Processor directed testbench
`timescale 1ns/1ns

module processorTb
	import cpuPkg::*;
();

	localparam int timeoutCycles = 500;
	localparam int resetCycles = 8;
	localparam int handlerAddr = 200;

	logic clk;
	logic rst;
	logic loadEn;
	logic [7:0] loadAddr;
	instrT loadInstr;
	regAddrT dbgAddr;
	wordT pc;
	wordT cyclesConsumed;
	wordT dbgData;
	logic halted;
	logic excepFlag;

	logic [31:0] lcgState = 32'h157f;
	logic [7:0] progAddr[$];
	instrT progData[$];

	clockGen clkSource (.clk(clk));

	processor #(
		.imemDepth  (256),
		.dmemDepth  (256),
		.handlerAddr(handlerAddr)
	) processor_inst (
		.clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadInstr(loadInstr), .dbgAddr(dbgAddr), .pc(pc), .halted(halted),
		.excepFlag(excepFlag), .cyclesConsumed(cyclesConsumed), .dbgData(dbgData)
	);

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic instrT encodeR(functT fn, regAddrT rs, regAddrT rt, regAddrT rd,
		logic [4:0] shamt);
		return {opRType, rs, rt, rd, shamt, fn};
	endfunction

	function automatic instrT encodeI(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instrT encodeJ(opcodeT op, logic [25:0] target);
		return {op, target};
	endfunction

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic compareWord(string name, wordT actual, wordT expected);
		if (actual !== expected) begin
			abortRun($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected));
		end
	endtask

	task automatic compareFlag(string name, logic actual, logic expected);
		if (actual !== expected) begin
			abortRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic checkReg(regAddrT addr, wordT expected);
		@(negedge clk);
		dbgAddr = addr;
		#1;
		compareWord($sformatf("reg%0d", addr), dbgData, expected);
	endtask

	task automatic place(logic [7:0] addr, instrT word);
		progAddr.push_back(addr);
		progData.push_back(word);
	endtask

	// Loads the queued program under reset, then releases reset.
	task automatic loadProgram();
		int heldCycles;
		rst = 1'b0;
		heldCycles = 0;
		foreach (progData[i]) begin
			@(negedge clk);
			loadEn = 1'b1;
			loadAddr = progAddr[i];
			loadInstr = progData[i];
			heldCycles++;
		end
		@(negedge clk);
		loadEn = 1'b0;
		heldCycles++;
		while (heldCycles < resetCycles) begin
			@(negedge clk);
			heldCycles++;
		end
		rst = 1'b1;
		progAddr.delete();
		progData.delete();
	endtask

	task automatic runToHalt();
		int waited;
		waited = 0;
		while (!halted && waited < timeoutCycles) begin
			@(negedge clk);
			waited++;
		end
		if (!halted) begin
			abortRun("Timeout: the processor did not halt within 500 cycles.");
		end
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic testArithmetic();
		wordT rnd;
		logic [15:0] immA, immB, immC;
		wordT a, b, c;
		rnd = nextRandom();
		// Force a negative first operand.
		immA = rnd[31:16] | 16'h8000;
		rnd = nextRandom();
		immB = rnd[31:16];
		rnd = nextRandom();
		immC = rnd[31:16];
		a = {{16{immA[15]}}, immA};
		b = {16'h0, immB};
		c = b ^ {16'h0, immC};
		place(0, encodeI(opAddi, 0, 1, immA));
		place(1, encodeI(opOri, 0, 2, immB));
		place(2, encodeI(opXori, 2, 3, immC));
		place(3, encodeR(fnAdd, 1, 2, 5, 0));
		place(4, encodeR(fnSub, 1, 3, 6, 0));
		place(5, encodeR(fnAnd, 1, 2, 7, 0));
		place(6, encodeR(fnOr, 1, 3, 8, 0));
		place(7, encodeR(fnXor, 1, 2, 9, 0));
		place(8, encodeR(fnSlt, 1, 3, 10, 0));
		place(9, encodeR(fnSlt, 3, 1, 11, 0));
		place(10, encodeR(fnSll, 0, 1, 12, 7));
		place(11, encodeR(fnSrl, 0, 1, 13, 9));
		place(12, encodeJ(opHlt, 0));
		loadProgram();
		runToHalt();
		compareWord("cyclesConsumed", cyclesConsumed, 13);
		checkReg(1, a);
		checkReg(2, b);
		checkReg(3, c);
		checkReg(5, a + b);
		checkReg(6, a - c);
		checkReg(7, a & b);
		checkReg(8, a | c);
		checkReg(9, a ^ b);
		// A is negative and c has a clear upper half, so a is the smaller one.
		checkReg(10, 1);
		checkReg(11, 0);
		checkReg(12, a << 7);
		checkReg(13, a >> 9);
	endtask

	task automatic testMemory();
		wordT rnd;
		logic [15:0] immA, immB;
		rnd = nextRandom();
		immA = rnd[31:16];
		rnd = nextRandom();
		immB = rnd[31:16];
		place(0, encodeI(opAddi, 0, 1, immA));
		place(1, encodeI(opAddi, 0, 2, immB));
		place(2, encodeI(opAddi, 0, 3, 20));
		place(3, encodeI(opSw, 3, 1, 0));
		place(4, encodeI(opSw, 3, 2, 5));
		place(5, encodeI(opLw, 3, 4, 0));
		place(6, encodeI(opLw, 3, 5, 5));
		place(7, encodeI(opAddi, 0, 0, 123));
		place(8, encodeR(fnAdd, 1, 2, 0, 0));
		// Absolute address 25 is base 20 plus offset 5.
		place(9, encodeI(opLw, 0, 6, 25));
		place(10, encodeJ(opHlt, 0));
		loadProgram();
		runToHalt();
		checkReg(4, {{16{immA[15]}}, immA});
		checkReg(5, {{16{immB[15]}}, immB});
		checkReg(6, {{16{immB[15]}}, immB});
		checkReg(0, 0);
	endtask

	task automatic testControlFlow();
		int loopCount;
		int pathLength;
		loopCount = 3;
		// Two setup steps, the loop body, then 5, 6, 8, 9, 12, 13, 10 and 15.
		pathLength = 2 + 3 * loopCount + 8;
		place(0, encodeI(opAddi, 0, 1, 16'(loopCount)));
		place(1, encodeI(opAddi, 0, 2, 0));
		place(2, encodeI(opAddi, 2, 2, 5));
		place(3, encodeI(opAddi, 1, 1, 16'hffff));
		place(4, encodeI(opBne, 1, 0, 16'hfffe));
		place(5, encodeI(opBeq, 1, 2, 3));
		place(6, encodeI(opBeq, 1, 0, 2));
		place(7, encodeI(opAddi, 0, 3, 99));
		place(8, encodeI(opBne, 1, 0, 5));
		place(9, encodeJ(opJal, 12));
		place(10, encodeJ(opJ, 15));
		place(11, encodeI(opAddi, 0, 3, 77));
		place(12, encodeI(opAddi, 0, 4, 44));
		place(13, encodeR(fnJr, 31, 0, 0, 0));
		place(14, encodeI(opAddi, 0, 5, 55));
		place(15, encodeJ(opHlt, 0));
		loadProgram();
		runToHalt();
		compareWord("pc", pc, 15);
		compareWord("cyclesConsumed", cyclesConsumed, pathLength);
		checkReg(1, 0);
		checkReg(2, 5 * loopCount);
		checkReg(3, 0);
		checkReg(4, 44);
		checkReg(5, 0);
		checkReg(31, 10);
	endtask

	task automatic testHalt();
		place(0, encodeI(opAddi, 0, 1, 1));
		place(1, encodeI(opAddi, 1, 2, 2));
		place(2, encodeJ(opHlt, 0));
		place(3, encodeI(opAddi, 0, 3, 9));
		loadProgram();
		runToHalt();
		compareWord("pc", pc, 2);
		compareFlag("halted", halted, 1'b1);
		compareFlag("excepFlag", excepFlag, 1'b0);
		compareWord("cyclesConsumed", cyclesConsumed, 3);
		repeat (20) @(negedge clk);
		compareWord("cyclesConsumed", cyclesConsumed, 3);
		compareWord("pc", pc, 2);
		checkReg(2, 3);
		checkReg(3, 0);
	endtask

	task automatic testException();
		place(0, encodeI(opAddi, 0, 1, 7));
		// Opcode 1 is not defined.
		place(1, instrT'(32'h0400_0000));
		place(2, encodeI(opAddi, 0, 9, 1));
		place(handlerAddr, encodeI(opAddi, 0, 10, 16'h00ad));
		place(handlerAddr + 1, encodeJ(opHlt, 0));
		loadProgram();
		runToHalt();
		compareFlag("excepFlag", excepFlag, 1'b1);
		compareWord("pc", pc, handlerAddr + 1);
		compareWord("cyclesConsumed", cyclesConsumed, 4);
		checkReg(1, 7);
		checkReg(9, 0);
		checkReg(10, 32'h0000_00ad);
	endtask

	task automatic testReset();
		place(0, encodeI(opAddi, 0, 1, 5));
		place(1, encodeI(opAddi, 1, 1, 1));
		place(2, encodeJ(opJ, 1));
		loadProgram();
		dbgAddr = 1;
		// Ten steps run address 0 once and address 1 five times.
		repeat (10) @(negedge clk);
		compareWord("cyclesConsumed", cyclesConsumed, 10);
		compareWord("reg1", dbgData, 10);
		rst = 1'b0;
		#1;
		compareWord("pc", pc, 0);
		compareWord("cyclesConsumed", cyclesConsumed, 0);
		compareWord("reg1", dbgData, 0);
		compareFlag("halted", halted, 1'b0);
		compareFlag("excepFlag", excepFlag, 1'b0);
	endtask

	initial begin
		rst = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadInstr = '0;
		dbgAddr = '0;
		testArithmetic();
		testMemory();
		testControlFlow();
		testHalt();
		testException();
		testReset();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- dv/processor_properties.sv
// Processor state assertions
`timescale 1ns/1ns

module processorProperties
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input wordT pc,
	input logic halted,
	input logic excepFlag,
	input wordT cyclesConsumed
);

	// A halted core holds its PC.
	pcFrozen: assert property (@(posedge clk) disable iff (!rst) halted |=> $stable(pc))
		else $error("pc changed while the core was halted");

	cyclesFrozen: assert property (@(posedge clk) disable iff (!rst)
		halted |=> $stable(cyclesConsumed))
		else $error("cyclesConsumed changed while the core was halted");

	// Exception flag is sticky until reset.
	excepSticky: assert property (@(posedge clk) disable iff (!rst) excepFlag |=> excepFlag)
		else $error("excepFlag fell without a reset");

endmodule

bind processor processorProperties props (
	.clk           (clk),
	.rst           (rst),
	.pc            (pc),
	.halted        (halted),
	.excepFlag     (excepFlag),
	.cyclesConsumed(cyclesConsumed)
);

//--- dv/clockGen.sv
// Testbench clock source
`timescale 1ns/1ns

module clockGen #(
	parameter int period = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#(period / 2);
		clk = ~clk;
	end

endmodule

//--- logic/processor.sv
// Single-cycle processor core
`timescale 1ns/1ns

module processor
	import cpuPkg::*;
#(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256,
	parameter int handlerAddr = 200,
	localparam int imemAddrWidth = $clog2(imemDepth),
	localparam int dmemAddrWidth = $clog2(dmemDepth)
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     loadEn,
	input  logic [imemAddrWidth-1:0] loadAddr,
	input  instrT                    loadInstr,
	input  regAddrT                  dbgAddr,
	output wordT                     pc,
	output logic                     halted,
	output logic                     excepFlag,
	output wordT                     cyclesConsumed,
	output wordT                     dbgData
);

	instrT   instr;
	pcSelT   pcSel;
	wordT    branchTarget, jumpTarget, regTarget;
	logic    regWrite, aluSrcImm, memRead, memWrite, memToReg;
	logic    useShamt, linkPc, isHalt, illegal;
	regAddrT writeReg;
	aluOpT   aluOp;
	wordT    immediate, rsData, rtData;
	wordT    operandA, operandB, aluResult;
	wordT    memData, loadData, writeBack;
	logic    fetchRun;

	// hlt keeps the PC on its own address.
	assign fetchRun = !halted && !isHalt;

	fetchUnit #(
		.imemDepth  (imemDepth),
		.handlerAddr(handlerAddr)
	) fetch (
		.clk(clk), .rst(rst), .run(fetchRun),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadInstr(loadInstr),
		.pcSel(pcSel), .branchTarget(branchTarget), .jumpTarget(jumpTarget),
		.regTarget(regTarget), .pc(pc), .instr(instr)
	);

	decodeUnit decode (
		.instr(instr), .pc(pc), .rsData(rsData), .rtData(rtData),
		.pcSel(pcSel), .branchTarget(branchTarget), .jumpTarget(jumpTarget),
		.regTarget(regTarget), .regWrite(regWrite), .writeReg(writeReg),
		.aluSrcImm(aluSrcImm), .aluOp(aluOp), .memRead(memRead),
		.memWrite(memWrite), .memToReg(memToReg), .immediate(immediate),
		.useShamt(useShamt), .linkPc(linkPc), .isHalt(isHalt), .illegal(illegal)
	);

	registerFile regFile (
		.clk(clk), .rst(rst), .we(regWrite && !halted),
		.readAddr1(instr.rs), .readAddr2(instr.rt), .writeAddr(writeReg),
		.writeData(writeBack), .readData1(rsData), .readData2(rtData),
		.dbgAddr(dbgAddr), .dbgData(dbgData)
	);

	// ========================================
	// Execute
	// ========================================
	always_comb begin
		if (useShamt) begin
			operandA = rtData;
			operandB = wordT'(instr.shamt);
		end else if (linkPc) begin
			operandA = pc;
			operandB = wordT'(1);
		end else begin
			operandA = rsData;
			operandB = aluSrcImm ? immediate : rtData;
		end
	end

	alu execUnit (
		.operandA(operandA), .operandB(operandB), .opSel(aluOp),
		.result(aluResult), .zero()
	);

	wordMemory #(
		.entryT(wordT),
		.depth (dmemDepth)
	) dataStore (
		.clk      (clk),
		.we       (memWrite && !halted),
		.writeAddr(aluResult[dmemAddrWidth-1:0]),
		.writeData(rtData),
		.readAddr (aluResult[dmemAddrWidth-1:0]),
		.readData (memData)
	);

	assign loadData = memRead ? memData : '0;
	assign writeBack = memToReg ? loadData : aluResult;

	// ========================================
	// Core state
	// ========================================
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			halted <= 1'b0;
			excepFlag <= 1'b0;
			cyclesConsumed <= '0;
		end else if (!halted) begin
			cyclesConsumed <= cyclesConsumed + wordT'(1);
			if (isHalt) begin
				halted <= 1'b1;
			end
			// Sticky until the next reset.
			if (illegal) begin
				excepFlag <= 1'b1;
			end
		end
	end

endmodule

//--- logic/fetchUnit.sv
// Instruction fetch
`timescale 1ns/1ns

module fetchUnit
	import cpuPkg::*;
#(
	parameter int imemDepth = 256,
	parameter int handlerAddr = 200,
	localparam int addrWidth = $clog2(imemDepth)
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 run,
	input  logic                 loadEn,
	input  logic [addrWidth-1:0] loadAddr,
	input  instrT                loadInstr,
	input  pcSelT                pcSel,
	input  wordT                 branchTarget,
	input  wordT                 jumpTarget,
	input  wordT                 regTarget,
	output wordT                 pc,
	output instrT                instr
);

	wordT pcPlusOne;
	wordT nextPc;

	assign pcPlusOne = pc + wordT'(1);

	// ========================================
	// Next PC
	// ========================================
	always_comb begin
		case (pcSel)
			pcBranch:  nextPc = branchTarget;
			pcJump:    nextPc = jumpTarget;
			pcReg:     nextPc = regTarget;
			pcHandler: nextPc = wordT'(handlerAddr);
			default:   nextPc = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
		end else if (run) begin
			pc <= nextPc;
		end
	end

	// ========================================
	// Instruction store
	// ========================================
	// Low PC bits index the store, so the PC wraps at imemDepth.
	wordMemory #(
		.entryT(instrT),
		.depth (imemDepth)
	) instrStore (
		.clk      (clk),
		.we       (loadEn),
		.writeAddr(loadAddr),
		.writeData(loadInstr),
		.readAddr (pc[addrWidth-1:0]),
		.readData (instr)
	);

endmodule

//--- logic/decodeUnit.sv
// Instruction decoder
`timescale 1ns/1ns

module decodeUnit
	import cpuPkg::*;
(
	input  instrT   instr,
	input  wordT    pc,
	input  wordT    rsData,
	input  wordT    rtData,
	output pcSelT   pcSel,
	output wordT    branchTarget,
	output wordT    jumpTarget,
	output wordT    regTarget,
	output logic    regWrite,
	output regAddrT writeReg,
	output logic    aluSrcImm,
	output aluOpT   aluOp,
	output logic    memRead,
	output logic    memWrite,
	output logic    memToReg,
	output wordT    immediate,
	output logic    useShamt,
	output logic    linkPc,
	output logic    isHalt,
	output logic    illegal
);

	logic zeroExtend;
	logic operandsEqual;

	// Logic immediates are zero-extended.
	assign zeroExtend = (instr.opcode == opAndi) || (instr.opcode == opOri) ||
		(instr.opcode == opXori);
	assign immediate = zeroExtend ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	assign operandsEqual = (rsData == rtData);
	assign branchTarget = pc + immediate;
	assign jumpTarget = {6'b0, instr[25:0]};
	assign regTarget = rsData;

	always_comb begin
		pcSel = pcSeq;
		regWrite = 1'b0;
		writeReg = instr.rt;
		aluSrcImm = 1'b0;
		aluOp = aluAdd;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		useShamt = 1'b0;
		linkPc = 1'b0;
		isHalt = 1'b0;
		illegal = 1'b0;
		case (instr.opcode)
			opRType: begin
				regWrite = 1'b1;
				writeReg = instr.rd;
				case (instr.funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr:  aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnSlt: aluOp = aluSlt;
					fnSll: begin
						aluOp = aluSll;
						useShamt = 1'b1;
					end
					fnSrl: begin
						aluOp = aluSrl;
						useShamt = 1'b1;
					end
					fnJr: begin
						regWrite = 1'b0;
						pcSel = pcReg;
					end
					default: begin
						regWrite = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			opAddi, opAndi, opOri, opXori: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				if (instr.opcode == opAndi) begin
					aluOp = aluAnd;
				end else if (instr.opcode == opOri) begin
					aluOp = aluOr;
				end else if (instr.opcode == opXori) begin
					aluOp = aluXor;
				end
			end
			opLw: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				memRead = 1'b1;
				memToReg = 1'b1;
			end
			opSw: begin
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
			end
			opBeq: if (operandsEqual) pcSel = pcBranch;
			opBne: if (!operandsEqual) pcSel = pcBranch;
			opJ:   pcSel = pcJump;
			opJal: begin
				// Link value is pc + 1 through the ALU
				pcSel = pcJump;
				regWrite = 1'b1;
				writeReg = linkReg;
				linkPc = 1'b1;
			end
			opHlt:   isHalt = 1'b1;
			default: illegal = 1'b1;
		endcase
		if (illegal) begin
			pcSel = pcHandler;
		end
	end

endmodule

//--- logic/registerFile.sv
// General purpose registers
`timescale 1ns/1ns

module registerFile
	import cpuPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    we,
	input  regAddrT readAddr1,
	input  regAddrT readAddr2,
	input  regAddrT writeAddr,
	input  wordT    writeData,
	output wordT    readData1,
	output wordT    readData2,
	input  regAddrT dbgAddr,
	output wordT    dbgData
);

	wordT regs [regCount];

	// Register 0 is hardwired to zero.
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
	assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

//--- logic/alu.sv
// Arithmetic logic unit
`timescale 1ns/1ns

module alu
	import cpuPkg::*;
(
	input  wordT  operandA,
	input  wordT  operandB,
	input  aluOpT opSel,
	output wordT  result,
	output logic  zero
);

	logic [4:0] shiftAmount;

	assign shiftAmount = operandB[4:0];

	always_comb begin
		case (opSel)
			aluAdd:   result = operandA + operandB;
			aluSub:   result = operandA - operandB;
			aluAnd:   result = operandA & operandB;
			aluOr:    result = operandA | operandB;
			aluXor:   result = operandA ^ operandB;
			// Signed compare.
			aluSlt:   result = wordT'($signed(operandA) < $signed(operandB));
			aluSll:   result = operandA << shiftAmount;
			aluSrl:   result = operandA >> shiftAmount;
			aluPassB: result = operandB;
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- logic/wordMemory.sv
// Generic word memory
`timescale 1ns/1ns

module wordMemory #(
	parameter type entryT = logic [31:0],
	parameter int depth = 256,
	localparam int addrWidth = $clog2(depth)
) (
	input  logic                 clk,
	input  logic                 we,
	input  logic [addrWidth-1:0] writeAddr,
	input  entryT                writeData,
	input  logic [addrWidth-1:0] readAddr,
	output entryT                readData
);

	entryT mem [depth];

	// Read is combinational.
	assign readData = mem[readAddr];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[writeAddr] <= writeData;
		end
	end

endmodule

//--- logic/cpuPkg.sv
// Processor shared types
package cpuPkg;

	localparam int wordWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;

	// Return address register for jal.
	localparam regAddrT linkReg = regAddrT'(31);

	// Field layout. Immediate is bits 15:0, jump target bits 25:0.
	typedef struct packed {
		logic [5:0] opcode;
		regAddrT    rs;
		regAddrT    rt;
		regAddrT    rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrT;

	typedef enum logic [5:0] {
		opRType = 6'd0,
		opJ     = 6'd2,
		opJal   = 6'd3,
		opBeq   = 6'd4,
		opBne   = 6'd5,
		opAddi  = 6'd8,
		opAndi  = 6'd12,
		opOri   = 6'd13,
		opXori  = 6'd14,
		opLw    = 6'd35,
		opSw    = 6'd43,
		opHlt   = 6'd63
	} opcodeT;

	typedef enum logic [5:0] {
		fnSll = 6'd0,
		fnSrl = 6'd2,
		fnJr  = 6'd8,
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnXor = 6'd38,
		fnSlt = 6'd42
	} functT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluPassB
	} aluOpT;

	// Next-PC source.
	typedef enum logic [2:0] {
		pcSeq,
		pcBranch,
		pcJump,
		pcReg,
		pcHandler
	} pcSelT;

endpackage
